// File: src/sdio_macros.svh
`ifndef SDIO_MACROS_SVH
`define SDIO_MACROS_SVH

// Card constants
`define SDIO_RCA            16'h0001
`define SDIO_NUM_FUNCS      3'd1
`define SDIO_MEM_PRESENT    1'b0
`define SDIO_IO_OCR         24'hFFFF00
`define SDIO_VHS_DEFAULT    4'h1

// CMD52 argument fields
`define CMD52_ARG_RW_FLAG   31
`define CMD52_ARG_FNUM      30:28
`define CMD52_ARG_RAW_FLAG  27
`define CMD52_ARG_REG_ADDR  25:9
`define CMD52_ARG_WR_DATA   7:0

// CMD7 and CMD8 argument fields
`define CMD7_ARG_RCA        15:0
`define CMD8_ARG_VHS        11:8
`define CMD8_ARG_PATTERN    7:0

// Response bit positions, CRC field left to the PHY
`define RSP_INDEX           45:40
`define R1_CRC_ERROR        31
`define R1_ILLEGAL          30
`define R1_CUR_STATE        20:17
`define R4_READY            39
`define R4_NUM_FUNCS        38:36
`define R4_MEM_PRESENT      35
`define R4_IO_OCR           31:8
`define R5_CRC_ERROR        23
`define R5_ILLEGAL          22
`define R5_STATE            21:20
`define R5_DATA             15:8
`define R6_RCA              39:24
`define R6_CRC_ERROR        23
`define R6_ILLEGAL          22
`define R7_VHS              19:16
`define R7_PATTERN          15:8

`endif

// File: src/sdio_pkg.sv
`default_nettype none

package sdio_pkg;

  // Supported command indices
  typedef enum logic [5:0] {
    CMD_GO_IDLE      = 6'd0,
    CMD_SEND_RCA     = 6'd3,
    CMD_IO_SEND_OP   = 6'd5,
    CMD_SEL_DESEL    = 6'd7,
    CMD_SEND_IF_COND = 6'd8,
    CMD_GO_INACTIVE  = 6'd15,
    CMD_IO_RW_DIRECT = 6'd52
  } sd_cmd_e;

  typedef enum logic [2:0] {
    ST_INIT,
    ST_STANDBY,
    ST_COMMAND,
    ST_TRANSFER,
    ST_INACTIVE
  } card_state_e;

  typedef enum logic [2:0] {
    RSP_R1,
    RSP_R4,
    RSP_R5,
    RSP_R6,
    RSP_R7
  } rsp_kind_e;

  typedef struct packed {
    sd_cmd_e     index;
    logic [31:0] arg;
  } cmd_t;

  // Direct register access to one function
  typedef struct packed {
    logic        write_flag;
    logic        raw_flag;
    logic [2:0]  func_num;
    logic [16:0] reg_addr;
    logic [7:0]  write_data;
  } func_req_t;

  typedef struct packed {
    rsp_kind_e   kind;
    sd_cmd_e     index;
    logic [31:0] arg;
    logic        crc_error;
    logic        illegal;
    logic [1:0]  r5_state;
  } rsp_req_t;

  typedef logic [47:0] rsp_t;

endpackage

`default_nettype wire

// File: src/sdio_card_fsm.sv
`timescale 1ns/1ns
`default_nettype none

`include "sdio_macros.svh"

module sdio_card_fsm (
  input  wire                     sdio_clk,
  input  wire                     rst,
  input  wire                     i_cmd_stb,
  input  wire                     i_cmd_crc_good,
  input  wire sdio_pkg::cmd_t     i_cmd,
  input  wire                     i_done_stb,
  output logic                    o_rsp_req_stb,
  output sdio_pkg::rsp_req_t      o_rsp_req,
  output logic                    o_func_start
);

  sdio_pkg::card_state_e state;
  sdio_pkg::card_state_e next_state;
  sdio_pkg::rsp_kind_e   rsp_kind;
  logic                  crc_error_flag;
  logic                  illegal_flag;
  logic                  rsp_valid;
  logic                  func_start;
  logic                  cmd_illegal;
  logic                  clr_illegal;
  logic                  rca_match;
  logic [1:0]            r5_code;

  assign rca_match = (i_cmd.arg[`CMD7_ARG_RCA] == `SDIO_RCA);

  assign r5_code = (state == sdio_pkg::ST_COMMAND)  ? 2'b01 :
                   (state == sdio_pkg::ST_TRANSFER) ? 2'b10 : 2'b00;

  // Command decode against the current card state
  always_comb begin
    next_state  = state;
    rsp_kind    = sdio_pkg::RSP_R1;
    rsp_valid   = 1'b0;
    func_start  = 1'b0;
    cmd_illegal = 1'b0;
    clr_illegal = 1'b0;
    case (i_cmd.index)
      sdio_pkg::CMD_IO_SEND_OP: begin
        rsp_kind    = sdio_pkg::RSP_R4;
        rsp_valid   = (state == sdio_pkg::ST_INIT);
        cmd_illegal = (state != sdio_pkg::ST_INIT);
      end
      sdio_pkg::CMD_SEND_RCA: begin
        rsp_kind = sdio_pkg::RSP_R6;
        if (state == sdio_pkg::ST_INIT || state == sdio_pkg::ST_STANDBY) begin
          next_state = sdio_pkg::ST_STANDBY;
          rsp_valid  = 1'b1;
        end else begin
          cmd_illegal = 1'b1;
        end
      end
      sdio_pkg::CMD_SEL_DESEL: begin
        // Own RCA selects, any other RCA deselects
        if (state == sdio_pkg::ST_STANDBY || state == sdio_pkg::ST_COMMAND) begin
          rsp_valid  = 1'b1;
          next_state = rca_match ? sdio_pkg::ST_COMMAND : sdio_pkg::ST_STANDBY;
        end else begin
          cmd_illegal = 1'b1;
        end
      end
      sdio_pkg::CMD_IO_RW_DIRECT: begin
        rsp_kind = sdio_pkg::RSP_R5;
        if (state == sdio_pkg::ST_COMMAND) begin
          next_state = sdio_pkg::ST_TRANSFER;
          rsp_valid  = 1'b1;
          func_start = 1'b1;
        end else begin
          cmd_illegal = 1'b1;
        end
      end
      sdio_pkg::CMD_GO_INACTIVE: begin
        next_state  = sdio_pkg::ST_INACTIVE;
        cmd_illegal = (state == sdio_pkg::ST_INACTIVE);
      end
      sdio_pkg::CMD_GO_IDLE: begin
        clr_illegal = 1'b1;
        rsp_valid   = 1'b1;
      end
      sdio_pkg::CMD_SEND_IF_COND: begin
        clr_illegal = 1'b1;
        rsp_kind    = sdio_pkg::RSP_R7;
        rsp_valid   = |(i_cmd.arg[`CMD8_ARG_VHS] & `SDIO_VHS_DEFAULT);
      end
      default: begin
        cmd_illegal = 1'b1;
      end
    endcase
  end

  always_ff @(posedge sdio_clk) begin
    if (rst) begin
      state          <= sdio_pkg::ST_INIT;
      crc_error_flag <= 1'b0;
      illegal_flag   <= 1'b0;
      o_rsp_req_stb  <= 1'b0;
      o_func_start   <= 1'b0;
    end else begin
      o_rsp_req_stb <= 1'b0;
      o_func_start  <= 1'b0;
      if (i_done_stb && state == sdio_pkg::ST_TRANSFER) begin
        state <= sdio_pkg::ST_COMMAND;
      end
      if (i_cmd_stb && !i_cmd_crc_good) begin
        crc_error_flag <= 1'b1;
      end else if (i_cmd_stb) begin
        state         <= next_state;
        o_rsp_req_stb <= rsp_valid;
        o_func_start  <= func_start;
        // Flags go out with the response, then start over
        if (rsp_valid) begin
          crc_error_flag <= 1'b0;
          illegal_flag   <= 1'b0;
        end else if (cmd_illegal) begin
          illegal_flag <= 1'b1;
        end else if (clr_illegal) begin
          illegal_flag <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge sdio_clk) begin
    if (i_cmd_stb) begin
      o_rsp_req.kind      <= rsp_kind;
      o_rsp_req.index     <= i_cmd.index;
      o_rsp_req.arg       <= i_cmd.arg;
      o_rsp_req.crc_error <= crc_error_flag;
      o_rsp_req.illegal   <= illegal_flag && !clr_illegal;
      o_rsp_req.r5_state  <= r5_code;
    end
  end

  // Every function start is paired with its R5 request
  a_start_has_r5 : assert property (@(posedge sdio_clk) disable iff (rst)
    o_func_start |-> (o_rsp_req_stb && o_rsp_req.kind == sdio_pkg::RSP_R5));

endmodule

`default_nettype wire

// File: src/sdio_func_request.sv
`timescale 1ns/1ns
`default_nettype none

`include "sdio_macros.svh"

module sdio_func_request (
  input  wire                     sdio_clk,
  input  wire                     rst,
  input  wire sdio_pkg::cmd_t     i_cmd,
  input  wire                     i_func_start,
  input  wire                     i_func_done,
  input  wire [7:0]               i_func_read_data,
  output logic                    o_func_stb,
  output sdio_pkg::func_req_t     o_func_req,
  output logic                    o_done_stb,
  output logic [7:0]              o_done_data
);

  logic [31:0] arg_q;
  logic        busy;

  // Start arrives one cycle after the command, so keep its argument
  always_ff @(posedge sdio_clk) begin
    arg_q <= i_cmd.arg;
    if (i_func_start) begin
      o_func_req.write_flag <= arg_q[`CMD52_ARG_RW_FLAG];
      o_func_req.raw_flag   <= arg_q[`CMD52_ARG_RAW_FLAG];
      o_func_req.func_num   <= arg_q[`CMD52_ARG_FNUM];
      o_func_req.reg_addr   <= arg_q[`CMD52_ARG_REG_ADDR];
      o_func_req.write_data <= arg_q[`CMD52_ARG_WR_DATA];
    end
    if (i_func_done) begin
      o_done_data <= i_func_read_data;
    end
  end

  always_ff @(posedge sdio_clk) begin
    if (rst) begin
      o_func_stb <= 1'b0;
      o_done_stb <= 1'b0;
      busy       <= 1'b0;
    end else begin
      o_func_stb <= i_func_start;
      o_done_stb <= i_func_done && busy;
      if (i_func_start) begin
        busy <= 1'b1;
      end else if (i_func_done) begin
        busy <= 1'b0;
      end
    end
  end

  a_done_when_busy : assert property (@(posedge sdio_clk) disable iff (rst)
    i_func_done |-> busy);

endmodule

`default_nettype wire

// File: src/sdio_rsp_builder.sv
`timescale 1ns/1ns
`default_nettype none

`include "sdio_macros.svh"

module sdio_rsp_builder (
  input  wire                     sdio_clk,
  input  wire                     rst,
  input  wire                     i_rsp_req_stb,
  input  wire sdio_pkg::rsp_req_t i_rsp_req,
  input  wire                     i_done_stb,
  input  wire [7:0]               i_done_data,
  output logic                    o_rsps_stb,
  output sdio_pkg::rsp_t          o_rsps
);

  sdio_pkg::rsp_req_t pend_req;
  logic               r5_pending;
  logic               issue_now;
  logic               issue_r5;

  function automatic sdio_pkg::rsp_t build_rsp(input sdio_pkg::rsp_req_t req,
                                               input logic [7:0] data);
    sdio_pkg::rsp_t rsp;
    rsp             = '0;
    rsp[`RSP_INDEX] = req.index;
    case (req.kind)
      sdio_pkg::RSP_R1: begin
        rsp[`R1_CRC_ERROR] = req.crc_error;
        rsp[`R1_ILLEGAL]   = req.illegal;
        rsp[`R1_CUR_STATE] = 4'hF;
      end
      sdio_pkg::RSP_R4: begin
        rsp[`RSP_INDEX]      = 6'h3F;
        rsp[`R4_READY]       = 1'b1;
        rsp[`R4_NUM_FUNCS]   = `SDIO_NUM_FUNCS;
        rsp[`R4_MEM_PRESENT] = `SDIO_MEM_PRESENT;
        rsp[`R4_IO_OCR]      = `SDIO_IO_OCR;
      end
      sdio_pkg::RSP_R5: begin
        rsp[`R5_CRC_ERROR] = req.crc_error;
        rsp[`R5_ILLEGAL]   = req.illegal;
        rsp[`R5_STATE]     = req.r5_state;
        rsp[`R5_DATA]      = data;
      end
      sdio_pkg::RSP_R6: begin
        rsp[`R6_RCA]       = `SDIO_RCA;
        rsp[`R6_CRC_ERROR] = req.crc_error;
        rsp[`R6_ILLEGAL]   = req.illegal;
      end
      default: begin
        rsp[`R7_VHS]     = req.arg[`CMD8_ARG_VHS] & `SDIO_VHS_DEFAULT;
        rsp[`R7_PATTERN] = req.arg[`CMD8_ARG_PATTERN];
      end
    endcase
    return rsp;
  endfunction

  assign issue_now = i_rsp_req_stb && (i_rsp_req.kind != sdio_pkg::RSP_R5);
  assign issue_r5  = r5_pending && i_done_stb;

  always_ff @(posedge sdio_clk) begin
    if (rst) begin
      o_rsps_stb <= 1'b0;
      r5_pending <= 1'b0;
    end else begin
      o_rsps_stb <= issue_now || issue_r5;
      if (i_rsp_req_stb && !issue_now) begin
        r5_pending <= 1'b1;
      end else if (issue_r5) begin
        r5_pending <= 1'b0;
      end
    end
  end

  // R5 waits here for the function's read byte
  always_ff @(posedge sdio_clk) begin
    if (i_rsp_req_stb && !issue_now) begin
      pend_req <= i_rsp_req;
    end
    if (issue_now) begin
      o_rsps <= build_rsp(i_rsp_req, 8'h00);
    end else if (issue_r5) begin
      o_rsps <= build_rsp(pend_req, i_done_data);
    end
  end

  a_no_req_while_pending : assert property (@(posedge sdio_clk) disable iff (rst)
    r5_pending |-> !i_rsp_req_stb);

endmodule

`default_nettype wire

// File: src/sdio_card_control.sv
`timescale 1ns/1ns
`default_nettype none

module sdio_card_control (
  input  wire                      sdio_clk,
  input  wire                      rst,
  input  wire                      i_cmd_stb,
  input  wire                      i_cmd_crc_good,
  input  wire sdio_pkg::cmd_t      i_cmd,
  input  wire                      i_func_done,
  input  wire [7:0]                i_func_read_data,
  output wire                      o_func_stb,
  output wire sdio_pkg::func_req_t o_func_req,
  output wire                      o_rsps_stb,
  output wire sdio_pkg::rsp_t      o_rsps
);

  wire                     rsp_req_stb;
  wire sdio_pkg::rsp_req_t rsp_req;
  wire                     func_start;
  wire                     done_stb;
  wire [7:0]               done_data;

  sdio_card_fsm u_card_fsm (
    .sdio_clk         (sdio_clk),
    .rst              (rst),
    .i_cmd_stb        (i_cmd_stb),
    .i_cmd_crc_good   (i_cmd_crc_good),
    .i_cmd            (i_cmd),
    .i_done_stb       (done_stb),
    .o_rsp_req_stb    (rsp_req_stb),
    .o_rsp_req        (rsp_req),
    .o_func_start     (func_start)
  );

  sdio_func_request u_func_request (
    .sdio_clk         (sdio_clk),
    .rst              (rst),
    .i_cmd            (i_cmd),
    .i_func_start     (func_start),
    .i_func_done      (i_func_done),
    .i_func_read_data (i_func_read_data),
    .o_func_stb       (o_func_stb),
    .o_func_req       (o_func_req),
    .o_done_stb       (done_stb),
    .o_done_data      (done_data)
  );

  sdio_rsp_builder u_rsp_builder (
    .sdio_clk         (sdio_clk),
    .rst              (rst),
    .i_rsp_req_stb    (rsp_req_stb),
    .i_rsp_req        (rsp_req),
    .i_done_stb       (done_stb),
    .i_done_data      (done_data),
    .o_rsps_stb       (o_rsps_stb),
    .o_rsps           (o_rsps)
  );

endmodule

`default_nettype wire

// File: testbench/tb_sdio_card_control.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sdio_card_control;

  localparam int DRIVE_DLY   = 10;
  localparam int RSP_TIMEOUT = 24;
  localparam int QUIET_WAIT  = 6;

  logic                sdio_clk;
  logic                rst;
  logic                i_cmd_stb;
  logic                i_cmd_crc_good;
  sdio_pkg::cmd_t      i_cmd;
  logic                i_func_done;
  logic [7:0]          i_func_read_data;
  logic                o_func_stb;
  sdio_pkg::func_req_t o_func_req;
  logic                o_rsps_stb;
  sdio_pkg::rsp_t      o_rsps;

  sdio_pkg::rsp_t        exp_q[$];
  string                 name_q[$];
  sdio_pkg::card_state_e m_state;
  logic                  m_crc;
  logic                  m_ill;
  logic [31:0]           last_arg;
  logic [31:0]           lfsr_state = 32'ha83a_f377;
  int                    errors;
  int                    checks;

  sdio_card_control u_sdio_card_control (
    .sdio_clk         (sdio_clk),
    .rst              (rst),
    .i_cmd_stb        (i_cmd_stb),
    .i_cmd_crc_good   (i_cmd_crc_good),
    .i_cmd            (i_cmd),
    .i_func_done      (i_func_done),
    .i_func_read_data (i_func_read_data),
    .o_func_stb       (o_func_stb),
    .o_func_req       (o_func_req),
    .o_rsps_stb       (o_rsps_stb),
    .o_rsps           (o_rsps)
  );

  initial begin
    sdio_clk = 1'b0;
    forever #50 sdio_clk = ~sdio_clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic sdio_pkg::func_req_t decode_cmd52(input logic [31:0] arg);
    sdio_pkg::func_req_t req;
    req.write_flag = arg[31];
    req.raw_flag   = arg[27];
    req.func_num   = arg[30:28];
    req.reg_addr   = arg[25:9];
    req.write_data = arg[7:0];
    return req;
  endfunction

  // Byte the function model returns for a request
  function automatic logic [7:0] func_byte(input logic raw, input logic [7:0] addr_lo,
                                           input logic [7:0] wdata);
    return raw ? wdata : (addr_lo ^ 8'h5A);
  endfunction

  function automatic sdio_pkg::rsp_t ref_rsp(input sdio_pkg::sd_cmd_e idx,
                                             input logic [31:0] arg,
                                             input logic crc_good,
                                             output logic has_rsp);
    sdio_pkg::rsp_t r;
    logic           legal;
    r       = '0;
    has_rsp = 1'b0;
    legal   = 1'b1;
    if (!crc_good) begin
      m_crc = 1'b1;
      return r;
    end
    r[45:40] = idx;
    case (idx)
      sdio_pkg::CMD_IO_SEND_OP: begin
        if (m_state == sdio_pkg::ST_INIT) begin
          has_rsp   = 1'b1;
          r[45:40]  = 6'h3F;
          r[39]     = 1'b1;
          r[38:36]  = 3'd1;
          r[35]     = 1'b0;
          r[31:8]   = 24'hFFFF00;
        end else begin
          legal = 1'b0;
        end
      end
      sdio_pkg::CMD_SEND_RCA: begin
        if (m_state == sdio_pkg::ST_INIT || m_state == sdio_pkg::ST_STANDBY) begin
          has_rsp  = 1'b1;
          r[39:24] = 16'h0001;
          r[23]    = m_crc;
          r[22]    = m_ill;
          m_state  = sdio_pkg::ST_STANDBY;
        end else begin
          legal = 1'b0;
        end
      end
      sdio_pkg::CMD_SEL_DESEL: begin
        if (m_state == sdio_pkg::ST_STANDBY || m_state == sdio_pkg::ST_COMMAND) begin
          has_rsp  = 1'b1;
          r[31]    = m_crc;
          r[30]    = m_ill;
          r[20:17] = 4'hF;
          m_state  = (arg[15:0] == 16'h0001) ? sdio_pkg::ST_COMMAND : sdio_pkg::ST_STANDBY;
        end else begin
          legal = 1'b0;
        end
      end
      sdio_pkg::CMD_IO_RW_DIRECT: begin
        // Card is back in command once the R5 has gone out
        if (m_state == sdio_pkg::ST_COMMAND) begin
          has_rsp  = 1'b1;
          r[23]    = m_crc;
          r[22]    = m_ill;
          r[21:20] = 2'b01;
          r[15:8]  = func_byte(arg[27], arg[16:9], arg[7:0]);
        end else begin
          legal = 1'b0;
        end
      end
      sdio_pkg::CMD_GO_INACTIVE: begin
        if (m_state != sdio_pkg::ST_INACTIVE) begin
          m_state = sdio_pkg::ST_INACTIVE;
        end else begin
          legal = 1'b0;
        end
      end
      sdio_pkg::CMD_GO_IDLE: begin
        m_ill    = 1'b0;
        has_rsp  = 1'b1;
        r[31]    = m_crc;
        r[20:17] = 4'hF;
      end
      sdio_pkg::CMD_SEND_IF_COND: begin
        m_ill = 1'b0;
        if (|(arg[11:8] & 4'h1)) begin
          has_rsp  = 1'b1;
          r[19:16] = arg[11:8] & 4'h1;
          r[15:8]  = arg[7:0];
        end
      end
      default: begin
        legal = 1'b0;
      end
    endcase
    if (has_rsp) begin
      m_crc = 1'b0;
      m_ill = 1'b0;
    end else if (!legal) begin
      m_ill = 1'b1;
    end
    return r;
  endfunction

  task automatic check_rsp(input string name, input sdio_pkg::rsp_t exp,
                           input sdio_pkg::rsp_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_func_req(input string name, input sdio_pkg::func_req_t exp,
                                input sdio_pkg::func_req_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Response compare, sampled mid-cycle
  always @(negedge sdio_clk) begin
    if (!rst && o_rsps_stb) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Response %h arrived when none was expected", o_rsps);
      end else begin
        check_rsp(name_q.pop_front(), exp_q.pop_front(), o_rsps);
      end
    end
  end

  // Function model answers each request after 1 to 8 cycles
  initial begin : func_model
    sdio_pkg::func_req_t req;
    int                  delay;
    forever begin
      @(negedge sdio_clk);
      if (!rst && o_func_stb) begin
        req = o_func_req;
        check_func_req("cmd52_func_req", decode_cmd52(last_arg), req);
        delay = int'(rand_bits(3)) + 1;
        repeat (delay) @(posedge sdio_clk);
        #DRIVE_DLY;
        i_func_done      = 1'b1;
        i_func_read_data = func_byte(req.raw_flag, req.reg_addr[7:0], req.write_data);
        @(posedge sdio_clk);
        #DRIVE_DLY;
        i_func_done = 1'b0;
      end
    end
  end

  task automatic send_cmd(input string name, input sdio_pkg::sd_cmd_e idx,
                          input logic [31:0] arg, input logic crc_good,
                          input bit check_lat);
    sdio_pkg::rsp_t exp;
    logic           has_rsp;
    int             cycles;
    exp = ref_rsp(idx, arg, crc_good, has_rsp);
    if (has_rsp) begin
      exp_q.push_back(exp);
      name_q.push_back(name);
    end
    if (idx == sdio_pkg::CMD_IO_RW_DIRECT) begin
      last_arg = arg;
    end
    @(posedge sdio_clk);
    #DRIVE_DLY;
    i_cmd_stb      = 1'b1;
    i_cmd.index    = idx;
    i_cmd.arg      = arg;
    i_cmd_crc_good = crc_good;
    @(posedge sdio_clk);
    #DRIVE_DLY;
    i_cmd_stb      = 1'b0;
    i_cmd_crc_good = 1'b1;
    cycles = 0;
    if (has_rsp) begin
      do begin
        @(negedge sdio_clk);
        cycles++;
      end while (!o_rsps_stb && cycles < RSP_TIMEOUT);
      if (!o_rsps_stb) begin
        errors++;
        $display("Timeout while waiting for the response to %s", name);
        exp_q.delete();
        name_q.delete();
      end else if (check_lat && cycles != 2) begin
        errors++;
        $display("FAILED %s latency: expected 2, actual %0d", name, cycles);
      end
    end else begin
      // Comparator flags anything that shows up here
      while (cycles < QUIET_WAIT) begin
        @(negedge sdio_clk);
        cycles++;
      end
    end
  endtask

  initial begin
    int          n;
    logic [31:0] arg;
    rst              = 1'b1;
    i_cmd_stb        = 1'b0;
    i_cmd_crc_good   = 1'b1;
    i_cmd            = '0;
    i_func_done      = 1'b0;
    i_func_read_data = 8'h00;
    last_arg         = '0;
    errors           = 0;
    checks           = 0;
    m_state          = sdio_pkg::ST_INIT;
    m_crc            = 1'b0;
    m_ill            = 1'b0;
    repeat (3) @(posedge sdio_clk);
    #DRIVE_DLY;
    rst = 1'b0;

    send_cmd("cmd5_r4", sdio_pkg::CMD_IO_SEND_OP, 32'h0, 1'b1, 1'b0);
    send_cmd("cmd3_r6", sdio_pkg::CMD_SEND_RCA, 32'h0, 1'b1, 1'b1);

    // Wrong RCA keeps the card in standby, so CMD52 is illegal
    send_cmd("cmd7_wrong_rca", sdio_pkg::CMD_SEL_DESEL, 32'h0000_0002, 1'b1, 1'b0);
    send_cmd("cmd52_standby", sdio_pkg::CMD_IO_RW_DIRECT, 32'h1000_0200, 1'b1, 1'b0);
    send_cmd("cmd7_select", sdio_pkg::CMD_SEL_DESEL, 32'h0000_0001, 1'b1, 1'b0);

    for (n = 0; n < 8; n++) begin
      arg = rand_bits(32);
      send_cmd($sformatf("cmd52_%0d", n), sdio_pkg::CMD_IO_RW_DIRECT, arg, 1'b1, 1'b0);
    end

    send_cmd("cmd7_bad_crc", sdio_pkg::CMD_SEL_DESEL, 32'h0000_0001, 1'b0, 1'b0);
    send_cmd("cmd7_crc_flag", sdio_pkg::CMD_SEL_DESEL, 32'h0000_0001, 1'b1, 1'b0);
    send_cmd("cmd7_clean", sdio_pkg::CMD_SEL_DESEL, 32'h0000_0001, 1'b1, 1'b0);

    send_cmd("cmd8_match", sdio_pkg::CMD_SEND_IF_COND, 32'h0000_01A5, 1'b1, 1'b0);
    send_cmd("cmd8_nomatch", sdio_pkg::CMD_SEND_IF_COND, 32'h0000_02C3, 1'b1, 1'b0);
    send_cmd("cmd15", sdio_pkg::CMD_GO_INACTIVE, 32'h0, 1'b1, 1'b0);
    send_cmd("cmd5_inactive", sdio_pkg::CMD_IO_SEND_OP, 32'h0, 1'b1, 1'b0);
    send_cmd("cmd3_inactive", sdio_pkg::CMD_SEND_RCA, 32'h0, 1'b1, 1'b0);
    send_cmd("cmd0_inactive", sdio_pkg::CMD_GO_IDLE, 32'h0, 1'b1, 1'b0);

    repeat (4) @(posedge sdio_clk);
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected responses never arrived", exp_q.size());
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+src
src/sdio_pkg.sv
src/sdio_card_fsm.sv
src/sdio_func_request.sv
src/sdio_rsp_builder.sv
src/sdio_card_control.sv
testbench/tb_sdio_card_control.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f \
  --top-module tb_sdio_card_control

sim_out=$(./obj_dir/Vtb_sdio_card_control)
echo "$sim_out"

if echo "$sim_out" | grep -qxF '** PASS **'; then
  exit 0
else
  exit 1
fi
